// File: Makefile
# Verilator simulation of the APB to IOb subsystem
TOP := apb_iob_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, pass if the log holds the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
+incdir+logic
logic/apb_iob_pkg.sv
logic/iob_if.sv
logic/apb2iob.sv
logic/iob_regfile.sv
logic/apb_iob_top.sv
sim/clk_gen.sv
sim/apb_iob_tb.sv

// File: logic/apb2iob.sv
`timescale 1ns/1ps
`include "apb_iob_settings.svh"

module apb2iob import apb_iob_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,

   // APB slave side
   input  logic  apb_sel_i,
   input  logic  apb_enable_i,
   input  logic  apb_write_i,
   input  addr_t apb_addr_i,
   input  data_t apb_wdata_i,
   input  strb_t apb_wstrb_i,
   output data_t apb_rdata_o,
   output logic  apb_ready_o,
   output logic  apb_slverr_o,

   // IOb master side
   iob_if.master iob
);

   bridge_state_e state_q;
   bridge_state_e state_nxt;

   logic avalid_q;
   logic avalid_nxt;

   logic apb_ready_q;
   logic apb_ready_nxt;
   logic apb_slverr_q;
   logic apb_slverr_nxt;

   // Control flow

   always_comb begin
      state_nxt      = state_q;
      avalid_nxt     = avalid_q;
      apb_ready_nxt  = 1'b0;  // Ready and error are one-cycle pulses
      apb_slverr_nxt = 1'b0;

      unique case (state_q)
         IDLE: begin
            // Selection starts a request on the next cycle
            if (apb_sel_i) begin
               avalid_nxt = 1'b1;
               state_nxt  = ACCESS;
            end
         end

         ACCESS: begin
            // Hold the request until the slave commits
            if (iob.ready_nxt) begin
               avalid_nxt     = 1'b0;
               apb_ready_nxt  = apb_write_i ? 1'b1 : iob.rvalid_nxt;
               apb_slverr_nxt = !apb_enable_i; // Enable missing in access phase
               state_nxt      = DONE;
            end
         end

         default: begin
            // Master must drop select before the next transfer
            if (!apb_sel_i) begin
               state_nxt = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q      <= IDLE;
         avalid_q     <= 1'b0;
         apb_ready_q  <= 1'b0;
         apb_slverr_q <= 1'b0;
      end else begin
         state_q      <= state_nxt;
         avalid_q     <= avalid_nxt;
         apb_ready_q  <= apb_ready_nxt;
         apb_slverr_q <= apb_slverr_nxt;
      end
   end

   // APB responses

   assign apb_ready_o  = apb_ready_q;
   assign apb_slverr_o = apb_slverr_q;

   // Register file data is valid in the ready cycle
   assign apb_rdata_o  = iob.rdata;

   // IOb request

   assign iob.avalid = avalid_q;
   assign iob.addr   = apb_addr_i;
   assign iob.wdata  = apb_wdata_i;

   // Reads carry no strobe, so the slave needs no write flag
   assign iob.wstrb  = apb_write_i ? apb_wstrb_i : strb_t'(0);

endmodule

// File: logic/apb_iob_pkg.sv
`include "apb_iob_settings.svh"

package apb_iob_pkg;

   // Byte address on both buses
   typedef logic [`APB_ADDR_W-1:0] addr_t;

   // Data word
   typedef logic [`APB_DATA_W-1:0] data_t;

   // One strobe bit per byte lane
   typedef logic [`APB_DATA_W/8-1:0] strb_t;

   // Bridge control flow
   typedef enum logic [1:0] {
      IDLE   = 2'd0, // Waiting for select
      ACCESS = 2'd1, // Request raised and waiting for the slave
      DONE   = 2'd2  // Transfer answered and waiting for deselect
   } bridge_state_e;

endpackage

// File: logic/apb_iob_settings.svh
`ifndef APB_IOB_SETTINGS_SVH
`define APB_IOB_SETTINGS_SVH

// Bus widths shared by APB and IOb sides
`define APB_ADDR_W 32
`define APB_DATA_W 32

// Register file depth in 32-bit words
`define REG_DEPTH 16

// Cycles the register file holds a request before accepting
`define REG_WAIT_CYCLES 2

`endif

// File: logic/apb_iob_top.sv
`timescale 1ns/1ps
`include "apb_iob_settings.svh"

module apb_iob_top import apb_iob_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,

   // APB slave port
   input  logic  apb_sel_i,
   input  logic  apb_enable_i,
   input  logic  apb_write_i,
   input  addr_t apb_addr_i,
   input  data_t apb_wdata_i,
   input  strb_t apb_wstrb_i,
   output data_t apb_rdata_o,
   output logic  apb_ready_o,
   output logic  apb_slverr_o
);

   // Internal IOb link between bridge and register file
   iob_if iob_link ();

   // APB to IOb bridge
   apb2iob apb2iob_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .apb_sel_i    (apb_sel_i),
      .apb_enable_i (apb_enable_i),
      .apb_write_i  (apb_write_i),
      .apb_addr_i   (apb_addr_i),
      .apb_wdata_i  (apb_wdata_i),
      .apb_wstrb_i  (apb_wstrb_i),
      .apb_rdata_o  (apb_rdata_o),
      .apb_ready_o  (apb_ready_o),
      .apb_slverr_o (apb_slverr_o),
      .iob          (iob_link.master)
   );

   // Register file with fixed wait states
   iob_regfile iob_regfile_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .iob   (iob_link.slave)
   );

endmodule

// File: logic/iob_if.sv
`timescale 1ns/1ps
`include "apb_iob_settings.svh"

interface iob_if import apb_iob_pkg::*; ();

   // Request driven by the master
   logic  avalid;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;  // Zero means read

   // Response driven by the slave
   logic  ready_nxt;  // Request taken at the coming edge
   logic  rvalid_nxt; // Read data valid after the coming edge
   data_t rdata;

   modport master (
      output avalid, addr, wdata, wstrb,
      input  ready_nxt, rvalid_nxt, rdata
   );

   modport slave (
      input  avalid, addr, wdata, wstrb,
      output ready_nxt, rvalid_nxt, rdata
   );

endinterface

// File: logic/iob_regfile.sv
`timescale 1ns/1ps
`include "apb_iob_settings.svh"

module iob_regfile import apb_iob_pkg::*; (
   input logic  clk_i,
   input logic  rst_i,

   // IOb slave side
   iob_if.slave iob
);

   localparam int IDX_W     = $clog2(`REG_DEPTH);
   localparam int CNT_W     = $clog2(`REG_WAIT_CYCLES + 2);
   localparam int NUM_BYTES = `APB_DATA_W / 8;

   data_t            mem [`REG_DEPTH];
   data_t            rdata_q;
   logic [CNT_W-1:0] wait_cnt;
   logic [IDX_W-1:0] word_idx;
   logic             in_range;
   logic             is_write;
   logic             accept;

   // Request decode

   assign word_idx = iob.addr[2 +: IDX_W];  // Word aligned
   assign in_range = iob.addr < addr_t'(4 * `REG_DEPTH);
   assign is_write = |iob.wstrb;

   // Wait states

   // Accept once the request has waited long enough
   assign accept = iob.avalid && (wait_cnt == CNT_W'(`REG_WAIT_CYCLES));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wait_cnt <= '0;
      end else if (!iob.avalid || accept) begin
         wait_cnt <= '0;  // Ready for the next request
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   assign iob.ready_nxt  = accept;
   assign iob.rvalid_nxt = accept && !is_write;

   // Storage

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < `REG_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (accept && is_write && in_range) begin
         // Merge only the strobed byte lanes
         for (int b = 0; b < NUM_BYTES; b++) begin
            if (iob.wstrb[b]) begin
               mem[word_idx][8*b +: 8] <= iob.wdata[8*b +: 8];
            end
         end
      end
   end

   // Read data

   // Held until the next accepted read
   always_ff @(posedge clk_i) begin
      if (accept && !is_write) begin
         if (in_range) begin
            rdata_q <= mem[word_idx];
         end else begin
            rdata_q <= '0;  // Unmapped space reads as zero
         end
      end
   end

   assign iob.rdata = rdata_q;

endmodule

// File: sim/apb_iob_tb.sv
`timescale 1ns/1ps
`include "apb_iob_settings.svh"

module apb_iob_tb import apb_iob_pkg::*; ();

   localparam int  IDX_W         = $clog2(`REG_DEPTH);
   localparam int  READY_TIMEOUT = 20;  // Cycles allowed for ready
   localparam time DRIVE_DLY     = 1;   // Input skew after the rising edge

   logic  clk_i;
   logic  rst_i;
   logic  apb_sel_i;
   logic  apb_enable_i;
   logic  apb_write_i;
   addr_t apb_addr_i;
   data_t apb_wdata_i;
   strb_t apb_wstrb_i;
   data_t apb_rdata_o;
   logic  apb_ready_o;
   logic  apb_slverr_o;

   data_t  model [`REG_DEPTH];  // Expected register contents
   int     data_errors;
   int     flag_errors;
   int     timeout_errors;
   integer seed;

   clk_gen #(.PERIOD_NS(100.0)) clk_gen_i (.clk_o(clk_i));

   apb_iob_top apb_iob_top_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .apb_sel_i    (apb_sel_i),
      .apb_enable_i (apb_enable_i),
      .apb_write_i  (apb_write_i),
      .apb_addr_i   (apb_addr_i),
      .apb_wdata_i  (apb_wdata_i),
      .apb_wstrb_i  (apb_wstrb_i),
      .apb_rdata_o  (apb_rdata_o),
      .apb_ready_o  (apb_ready_o),
      .apb_slverr_o (apb_slverr_o)
   );

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("FAIL %s: expected %h, got %h", name, exp, act);
         data_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s: expected %h, got %h", name, exp, act);
         flag_errors++;
      end
   endtask

   // Byte merge into the expected word and unmapped writes are dropped
   task automatic update_model(input addr_t addr, input data_t wdata, input strb_t strb);
      if (addr < addr_t'(4 * `REG_DEPTH)) begin
         for (int b = 0; b < `APB_DATA_W / 8; b++) begin
            if (strb[b]) begin
               model[addr[2 +: IDX_W]][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
   endtask

   function automatic data_t expected_read(input addr_t addr);
      if (addr < addr_t'(4 * `REG_DEPTH)) begin
         return model[addr[2 +: IDX_W]];
      end
      return '0;  // Unmapped space
   endfunction

   // One APB transfer with setup then access until ready
   task automatic run_transfer(
      input  logic  write,
      input  addr_t addr,
      input  data_t wdata,
      input  strb_t strb,
      input  logic  enable,  // Enable level in the access phase
      output data_t rdata,
      output logic  slverr
   );
      int   cycles;
      logic got_ready;
      cycles    = 0;
      got_ready = 1'b0;
      rdata     = '0;
      slverr    = 1'b0;
      @(posedge clk_i);
      #DRIVE_DLY;
      apb_sel_i    = 1'b1;  // Setup phase
      apb_enable_i = 1'b0;
      apb_write_i  = write;
      apb_addr_i   = addr;
      apb_wdata_i  = wdata;
      apb_wstrb_i  = strb;
      @(posedge clk_i);
      #DRIVE_DLY;
      apb_enable_i = enable;
      while (!got_ready && cycles < READY_TIMEOUT) begin
         @(posedge clk_i);
         #DRIVE_DLY;
         cycles++;
         got_ready = (apb_ready_o === 1'b1);
      end
      if (got_ready) begin
         rdata  = apb_rdata_o;
         slverr = apb_slverr_o;
      end else begin
         $display("Timeout: no ready within %0d cycles for address %h", cycles, addr);
         timeout_errors++;
      end
      apb_sel_i    = 1'b0;
      apb_enable_i = 1'b0;
   endtask

   task automatic apb_write(
      input  addr_t addr,
      input  data_t wdata,
      input  strb_t strb,
      input  logic  enable,
      output logic  slverr
   );
      data_t unused;
      run_transfer(1'b1, addr, wdata, strb, enable, unused, slverr);
      update_model(addr, wdata, strb);  // Written even on a protocol error
   endtask

   task automatic apb_read(input addr_t addr, output data_t rdata, output logic slverr);
      run_transfer(1'b0, addr, '0, '0, 1'b1, rdata, slverr);
   endtask

   task automatic verify_word(input addr_t addr);
      data_t rd;
      logic  err;
      apb_read(addr, rd, err);
      check_data("apb_rdata_o", expected_read(addr), rd);
      check_flag("apb_slverr_o", 1'b0, err);
   endtask

   task automatic verify_all_words();
      for (int i = 0; i < `REG_DEPTH; i++) begin
         verify_word(addr_t'(4 * i));
      end
   endtask

   task automatic reset_values();
      check_flag("apb_ready_o", 1'b0, apb_ready_o);
      check_flag("apb_slverr_o", 1'b0, apb_slverr_o);
      verify_all_words();  // Model is all zero here
   endtask

   task automatic full_word_writes();
      logic err;
      apb_write(32'h0000_0000, 32'hDEAD_BEEF, 4'hF, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_000C, 32'h1234_5678, 4'hF, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_001C, 32'hA5A5_5A5A, 4'hF, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_003C, 32'hFFFF_0001, 4'hF, 1'b1, err);  // Last word
      check_flag("apb_slverr_o", 1'b0, err);
      verify_all_words();
   endtask

   task automatic partial_strobes();
      logic err;
      apb_write(32'h0000_0004, 32'h1111_1111, 4'hF, 1'b1, err);
      apb_write(32'h0000_0004, 32'hAABB_CCDD, 4'b0101, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_0008, 32'h2222_2222, 4'hF, 1'b1, err);
      apb_write(32'h0000_0008, 32'h9955_6600, 4'b1000, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_000C, 32'h0000_7700, 4'b0010, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      verify_word(32'h0000_0004);
      verify_word(32'h0000_0008);
      verify_word(32'h0000_000C);
   endtask

   task automatic out_of_range();
      logic err;
      apb_write(32'h0000_0040, 32'hBAD0_0001, 4'hF, 1'b1, err);
      check_flag("apb_slverr_o", 1'b0, err);
      apb_write(32'h0000_0100, 32'hBAD0_0002, 4'hF, 1'b1, err);
      apb_write(32'hFFFF_FFFC, 32'hBAD0_0003, 4'hF, 1'b1, err);
      verify_all_words();
      verify_word(32'h0000_0040);
      verify_word(32'hFFFF_FFFC);
   endtask

   task automatic enable_error();
      logic err;
      apb_write(32'h0000_0014, 32'h0BAD_C0DE, 4'hF, 1'b0, err);
      check_flag("apb_slverr_o", 1'b1, err);
      verify_word(32'h0000_0014);  // Data landed despite the error
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      addr_t       addr;
      data_t       wdata;
      logic        err;
      for (int n = 0; n < 50; n++) begin
         r     = $random(seed);
         addr  = addr_t'(r & 32'h0000_007C);  // Half in range and half above
         wdata = $random(seed);
         if (r[31]) begin
            apb_write(addr, wdata, strb_t'(r[11:8]), 1'b1, err);
            check_flag("apb_slverr_o", 1'b0, err);
         end else begin
            verify_word(addr);
         end
      end
      verify_all_words();
   endtask

   initial begin
      seed           = 32'h1a525c66;
      data_errors    = 0;
      flag_errors    = 0;
      timeout_errors = 0;
      rst_i          = 1'b1;
      apb_sel_i      = 1'b0;
      apb_enable_i   = 1'b0;
      apb_write_i    = 1'b0;
      apb_addr_i     = '0;
      apb_wdata_i    = '0;
      apb_wstrb_i    = '0;
      for (int i = 0; i < `REG_DEPTH; i++) begin
         model[i] = '0;
      end
      repeat (8) @(posedge clk_i);
      #DRIVE_DLY;
      rst_i = 1'b0;

      reset_values();
      full_word_writes();
      partial_strobes();
      out_of_range();
      enable_error();
      random_traffic();

      $display("Errors: data %0d, flag %0d, timeout %0d",
               data_errors, flag_errors, timeout_errors);
      if (data_errors + flag_errors + timeout_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter real PERIOD_NS = 100.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   // Free running with a half period per phase
   always begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
   end

endmodule
